// ==== rtl/soc_pkg.sv ====
package soc_pkg;

    // bus widths
    localparam int ADDR_W    = 64;
    localparam int DATA_W    = 64;
    localparam int LS_TYPE_W = 3;

    // load/store type codes, shared by loads and stores
    localparam logic [LS_TYPE_W-1:0] LS_B  = 3'b000;
    localparam logic [LS_TYPE_W-1:0] LS_H  = 3'b001;
    localparam logic [LS_TYPE_W-1:0] LS_W  = 3'b010;
    localparam logic [LS_TYPE_W-1:0] LS_D  = 3'b011;
    localparam logic [LS_TYPE_W-1:0] LS_BU = 3'b100;
    localparam logic [LS_TYPE_W-1:0] LS_HU = 3'b101;
    localparam logic [LS_TYPE_W-1:0] LS_WU = 3'b110;

    // word ram
    localparam logic [ADDR_W-1:0] RAM_BASE = 64'h0000_0000_8000_0000;
    localparam int RAM_WORDS = 1024;
    localparam int RAM_AW    = 10;

    // single registers
    localparam logic [ADDR_W-1:0] KEY_ADDR      = 64'h0000_0000_1000_0000;
    localparam logic [ADDR_W-1:0] MTIMECMP_ADDR = 64'h0000_0000_0200_4000;

    // plic region, offsets relative to PLIC_BASE
    localparam logic [ADDR_W-1:0] PLIC_BASE              = 64'h0000_0000_0C00_0000;
    localparam logic [ADDR_W-1:0] PLIC_PENDING_OFS       = 64'h1000;
    localparam logic [ADDR_W-1:0] PLIC_ENABLE_OFS        = 64'h2000;
    localparam logic [ADDR_W-1:0] PLIC_CTX_ENABLE_STRIDE = 64'h80;
    localparam logic [ADDR_W-1:0] PLIC_THRESHOLD_OFS     = 64'h20_0000;
    localparam logic [ADDR_W-1:0] PLIC_CLAIM_OFS         = 64'h20_0004;
    localparam logic [ADDR_W-1:0] PLIC_CTX_STRIDE        = 64'h1000;
    localparam logic [ADDR_W-1:0] PLIC_SPAN              = 64'h40_0000;

    // interrupt sources, id 0 means no interrupt
    localparam int NUM_SRC    = 5;
    localparam int PRIO_W     = 3;
    localparam int KEY_SRC_ID = 1;
    localparam int SRC_ID_W   = $clog2(NUM_SRC + 1);
    // context 0 machine, context 1 supervisor
    localparam int NUM_CTX    = 2;

    // bus targets picked by the decoder
    typedef enum logic [1:0] {
        TGT_NONE,
        TGT_RAM,
        TGT_KEYTIME,
        TGT_PLIC
    } target_t;

endpackage

// ==== rtl/addr_decoder.sv ====
`timescale 1ns/100ps

module addr_decoder import soc_pkg::*; (
    input  logic [ADDR_W-1:0] addr,
    output target_t           target
);

    logic ram_hit;
    logic keytime_hit;
    logic plic_hit;

    // ram holds RAM_WORDS 32-bit words
    assign ram_hit = (addr >= RAM_BASE) && (addr < RAM_BASE + RAM_WORDS * 4);

    // keyboard and mtimecmp share one target
    assign keytime_hit = (addr == KEY_ADDR) || (addr == MTIMECMP_ADDR);

    // whole plic window, register select is done inside plic
    assign plic_hit = (addr >= PLIC_BASE) && (addr < PLIC_BASE + PLIC_SPAN);

    always_comb begin
        // unmapped falls through to none
        target = TGT_NONE;
        if (ram_hit) begin
            target = TGT_RAM;
        end else if (keytime_hit) begin
            target = TGT_KEYTIME;
        end else if (plic_hit) begin
            target = TGT_PLIC;
        end
    end

endmodule

// ==== rtl/bus_ctrl.sv ====
`timescale 1ns/100ps

module bus_ctrl import soc_pkg::*; (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  logic              read_enable,
    input  logic              write_enable,
    input  target_t           target,
    output logic              ram_stb,
    output logic              keytime_stb,
    output logic              plic_stb,
    output logic              acc_write,
    input  logic              ram_ack,
    input  logic [DATA_W-1:0] ram_rdata,
    input  logic              keytime_ack,
    input  logic [DATA_W-1:0] keytime_rdata,
    input  logic              plic_ack,
    input  logic [DATA_W-1:0] plic_rdata,
    output logic [DATA_W-1:0] rdata,
    output logic              read_done,
    output logic              write_done
);

    // request taken, strobe goes out next edge
    logic stage_q;
    // one-cycle access strobe
    logic stb_q;
    logic tgt_ack;
    logic [DATA_W-1:0] tgt_rdata;

    assign ram_stb     = stb_q && (target == TGT_RAM);
    assign keytime_stb = stb_q && (target == TGT_KEYTIME);
    assign plic_stb    = stb_q && (target == TGT_PLIC);

    // pick ack and data of the addressed target
    always_comb begin
        case (target)
            TGT_RAM: begin
                tgt_ack   = ram_ack;
                tgt_rdata = ram_rdata;
            end
            TGT_KEYTIME: begin
                tgt_ack   = keytime_ack;
                tgt_rdata = keytime_rdata;
            end
            TGT_PLIC: begin
                tgt_ack   = plic_ack;
                tgt_rdata = plic_rdata;
            end
            default: begin
                // nothing mapped, finish on the strobe with zero
                tgt_ack   = stb_q;
                tgt_rdata = '0;
            end
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            stage_q    <= 1'b0;
            stb_q      <= 1'b0;
            acc_write  <= 1'b0;
            read_done  <= 1'b1;
            write_done <= 1'b1;
            rdata      <= '0;
        end else begin
            stage_q <= read_enable || write_enable;
            stb_q   <= stage_q;
            // new request, done drops and direction is kept
            if (read_enable) begin
                read_done <= 1'b0;
                acc_write <= 1'b0;
            end
            if (write_enable) begin
                write_done <= 1'b0;
                acc_write  <= 1'b1;
            end
            // target answered, finish at this edge
            if (tgt_ack) begin
                if (acc_write) begin
                    write_done <= 1'b1;
                end else begin
                    read_done <= 1'b1;
                    rdata     <= tgt_rdata;
                end
            end
        end
    end

    // requester waits for both done flags before a new pulse
    a_no_overlap: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (read_enable || write_enable) |-> (read_done && write_done));

    a_one_dir: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        !(read_enable && write_enable));

    // a strobe only inside an open request
    a_stb_pending: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (ram_stb || keytime_stb || plic_stb) |-> !(read_done && write_done));

endmodule

// ==== rtl/ram_port.sv ====
`timescale 1ns/100ps

module ram_port import soc_pkg::*; (
    input  logic                 CLOCK_50,
    input  logic                 KEY0,
    input  logic                 stb,
    input  logic                 write,
    input  logic [ADDR_W-1:0]    addr,
    input  logic [LS_TYPE_W-1:0] ls_type,
    input  logic [DATA_W-1:0]    wdata,
    output logic                 ack,
    output logic [DATA_W-1:0]    rdata
);

    logic [31:0] mem [RAM_WORDS];
    logic [RAM_AW-1:0] idx;
    logic [RAM_AW-1:0] idx_next;
    logic [1:0] off;
    // second beat of a double
    logic hi_q;
    // low word of a double load
    logic [31:0] lo_q;

    assign idx      = addr[RAM_AW+1:2];
    assign idx_next = idx + 1'b1;
    assign off      = addr[1:0];

    // doubles answer one cycle late
    assign ack = (stb && (ls_type != LS_D)) || hi_q;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            hi_q <= 1'b0;
        end else begin
            hi_q <= stb && (ls_type == LS_D);
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (stb && write) begin
            case (ls_type)
                LS_B: mem[idx][{off, 3'b000} +: 8] <= wdata[7:0];
                LS_H: mem[idx][{off[1], 4'b0000} +: 16] <= wdata[15:0];
                // double writes its low word first
                LS_W, LS_D: mem[idx] <= wdata[31:0];
                default: ;
            endcase
        end
        if (hi_q && write) begin
            mem[idx_next] <= wdata[63:32];
        end
        if (stb) begin
            lo_q <= mem[idx];
        end
    end

    always_comb begin
        case (ls_type)
            LS_D: rdata = {mem[idx_next], lo_q};
            // narrow loads shift the whole word, no sign handling
            LS_B, LS_H, LS_W, LS_BU, LS_HU, LS_WU: rdata = {32'b0, mem[idx] >> {off, 3'b000}};
            default: rdata = '0;
        endcase
    end

    // halfword store lands on a lane boundary
    a_sh_even: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (stb && write && (ls_type == LS_H)) |-> !off[0]);

endmodule

// ==== rtl/key_timer_regs.sv ====
`timescale 1ns/100ps

module key_timer_regs import soc_pkg::*; (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  logic              stb,
    input  logic              write,
    input  logic [ADDR_W-1:0] addr,
    input  logic [DATA_W-1:0] wdata,
    input  logic              key_valid,
    input  logic [7:0]        key_ascii,
    output logic              ack,
    output logic [DATA_W-1:0] rdata,
    output logic              key_event
);

    logic [7:0] key_char;
    logic key_valid_d;
    logic [DATA_W-1:0] mtimecmp;
    logic mtimecmp_sel;

    assign mtimecmp_sel = (addr == MTIMECMP_ADDR);
    assign ack = stb;
    // anything else in this target is the key register
    assign rdata = mtimecmp_sel ? mtimecmp : {56'b0, key_char};

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            key_char    <= '0;
            key_valid_d <= 1'b0;
            key_event   <= 1'b0;
            mtimecmp    <= '0;
        end else begin
            key_valid_d <= key_valid;
            // single pulse on the rising edge of key_valid
            key_event <= key_valid && !key_valid_d;
            if (key_valid) begin
                key_char <= key_ascii;
            end
            if (stb && write && mtimecmp_sel) begin
                mtimecmp <= wdata;
            end
        end
    end

endmodule

// ==== rtl/plic.sv ====
`timescale 1ns/100ps

module plic import soc_pkg::*; (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  logic              stb,
    input  logic              write,
    input  logic [ADDR_W-1:0] addr,
    input  logic [DATA_W-1:0] wdata,
    input  logic [NUM_SRC:0]  irq_src,
    input  logic              key_event,
    output logic              ack,
    output logic [DATA_W-1:0] rdata,
    output logic              meip,
    output logic              seip
);

    logic [PRIO_W-1:0] prio [1:NUM_SRC];
    // bit 0 stays clear
    logic [NUM_SRC:0] pending;
    logic [NUM_SRC:0] enable [NUM_CTX];
    logic [PRIO_W-1:0] threshold [NUM_CTX];
    logic [SRC_ID_W-1:0] claim_id [NUM_CTX];

    logic [ADDR_W-1:0] ofs;
    logic [SRC_ID_W-1:0] prio_id;
    logic prio_sel;
    logic pend_sel;
    logic [NUM_CTX-1:0] en_sel;
    logic [NUM_CTX-1:0] thr_sel;
    logic [NUM_CTX-1:0] claim_sel;

    assign ofs = addr - PLIC_BASE;
    assign ack = stb;

    // priority words at 4 * id
    assign prio_id  = ofs[SRC_ID_W+1:2];
    assign prio_sel = (ofs >= 4) && (ofs <= 4 * NUM_SRC) && (ofs[1:0] == 2'b00);
    assign pend_sel = (ofs == PLIC_PENDING_OFS);

    always_comb begin
        for (int c = 0; c < NUM_CTX; c++) begin
            en_sel[c]    = (ofs == PLIC_ENABLE_OFS + c * PLIC_CTX_ENABLE_STRIDE);
            thr_sel[c]   = (ofs == PLIC_THRESHOLD_OFS + c * PLIC_CTX_STRIDE);
            claim_sel[c] = (ofs == PLIC_CLAIM_OFS + c * PLIC_CTX_STRIDE);
        end
    end

    // best enabled pending id per context, lowest id wins a tie
    always_comb begin : claim_search
        logic [PRIO_W-1:0] best;
        for (int c = 0; c < NUM_CTX; c++) begin
            best        = threshold[c];
            claim_id[c] = '0;
            for (int id = 1; id <= NUM_SRC; id++) begin
                if (pending[id] && enable[c][id] && (prio[id] > best)) begin
                    best        = prio[id];
                    claim_id[c] = id[SRC_ID_W-1:0];
                end
            end
        end
    end

    assign meip = (claim_id[0] != '0);
    assign seip = (claim_id[1] != '0);

    always_comb begin
        rdata = '0;
        if (prio_sel) begin
            rdata = {{(DATA_W-PRIO_W){1'b0}}, prio[prio_id]};
        end else if (pend_sel) begin
            rdata = {{(DATA_W-NUM_SRC-1){1'b0}}, pending};
        end
        for (int c = 0; c < NUM_CTX; c++) begin
            if (en_sel[c]) rdata = {{(DATA_W-NUM_SRC-1){1'b0}}, enable[c]};
            if (thr_sel[c]) rdata = {{(DATA_W-PRIO_W){1'b0}}, threshold[c]};
            if (claim_sel[c]) rdata = {{(DATA_W-SRC_ID_W){1'b0}}, claim_id[c]};
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            pending <= '0;
            for (int id = 1; id <= NUM_SRC; id++) begin
                prio[id] <= '0;
            end
            for (int c = 0; c < NUM_CTX; c++) begin
                enable[c]    <= '0;
                threshold[c] <= '0;
            end
        end else begin
            // sources only set pending
            for (int id = 1; id <= NUM_SRC; id++) begin
                if (irq_src[id] || (key_event && (id == KEY_SRC_ID))) begin
                    pending[id] <= 1'b1;
                end
            end
            for (int c = 0; c < NUM_CTX; c++) begin
                // claim read hands out the id and clears it
                if (stb && !write && claim_sel[c] && (claim_id[c] != '0)) begin
                    pending[claim_id[c]] <= 1'b0;
                end
                if (stb && write && en_sel[c]) enable[c] <= wdata[NUM_SRC:0];
                if (stb && write && thr_sel[c]) threshold[c] <= wdata[PRIO_W-1:0];
            end
            if (stb && write && prio_sel) begin
                prio[prio_id] <= wdata[PRIO_W-1:0];
            end
        end
    end

    a_claim_range: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (claim_id[0] <= NUM_SRC) && (claim_id[1] <= NUM_SRC));

endmodule

// ==== rtl/soc_bus.sv ====
`timescale 1ns/100ps

module soc_bus import soc_pkg::*; (
    input  logic                 CLOCK_50,
    input  logic                 KEY0,
    input  logic [ADDR_W-1:0]    addr,
    input  logic [LS_TYPE_W-1:0] ls_type,
    input  logic [DATA_W-1:0]    wdata,
    input  logic                 read_enable,
    input  logic                 write_enable,
    input  logic                 key_valid,
    input  logic [7:0]           key_ascii,
    input  logic [NUM_SRC:0]     irq_src,
    output logic [DATA_W-1:0]    rdata,
    output logic                 read_done,
    output logic                 write_done,
    output logic                 meip,
    output logic                 seip
);

    target_t target;
    logic ram_stb;
    logic keytime_stb;
    logic plic_stb;
    logic acc_write;
    logic ram_ack;
    logic keytime_ack;
    logic plic_ack;
    logic [DATA_W-1:0] ram_rdata;
    logic [DATA_W-1:0] keytime_rdata;
    logic [DATA_W-1:0] plic_rdata;
    // keyboard edge into plic source 1
    logic key_event;

    addr_decoder u_dec (
        .addr   (addr),
        .target (target)
    );

    bus_ctrl u_ctrl (
        .CLOCK_50      (CLOCK_50),
        .KEY0          (KEY0),
        .read_enable   (read_enable),
        .write_enable  (write_enable),
        .target        (target),
        .ram_stb       (ram_stb),
        .keytime_stb   (keytime_stb),
        .plic_stb      (plic_stb),
        .acc_write     (acc_write),
        .ram_ack       (ram_ack),
        .ram_rdata     (ram_rdata),
        .keytime_ack   (keytime_ack),
        .keytime_rdata (keytime_rdata),
        .plic_ack      (plic_ack),
        .plic_rdata    (plic_rdata),
        .rdata         (rdata),
        .read_done     (read_done),
        .write_done    (write_done)
    );

    ram_port u_ram (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .stb      (ram_stb),
        .write    (acc_write),
        .addr     (addr),
        .ls_type  (ls_type),
        .wdata    (wdata),
        .ack      (ram_ack),
        .rdata    (ram_rdata)
    );

    key_timer_regs u_keytime (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .stb       (keytime_stb),
        .write     (acc_write),
        .addr      (addr),
        .wdata     (wdata),
        .key_valid (key_valid),
        .key_ascii (key_ascii),
        .ack       (keytime_ack),
        .rdata     (keytime_rdata),
        .key_event (key_event)
    );

    plic u_plic (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .stb       (plic_stb),
        .write     (acc_write),
        .addr      (addr),
        .wdata     (wdata),
        .irq_src   (irq_src),
        .key_event (key_event),
        .ack       (plic_ack),
        .rdata     (plic_rdata),
        .meip      (meip),
        .seip      (seip)
    );

endmodule

// ==== testbench/bus_checker.sv ====
`timescale 1ns/100ps

module bus_checker import soc_pkg::*; (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  logic              read_done,
    input  logic              write_done,
    input  logic [DATA_W-1:0] rdata,
    input  logic              meip,
    input  logic              seip,
    input  logic [DATA_W-1:0] exp_rdata,
    input  logic [1:0]        exp_cycles,
    input  logic              exp_write,
    input  logic              irq_chk,
    input  logic              exp_meip,
    input  logic              exp_seip,
    output int                error_count,
    output int                done_count
);

    // negedges seen with a done flag low
    int low_cycles;
    logic busy;
    logic saw_read;
    logic saw_write;
    logic reset_checked;

    initial begin
        error_count   = 0;
        done_count    = 0;
        low_cycles    = 0;
        busy          = 1'b0;
        saw_read      = 1'b0;
        saw_write     = 1'b0;
        reset_checked = 1'b0;
    end

    // outputs are settled at the falling edge
    always @(negedge CLOCK_50) begin
        if (!KEY0) begin
            // reset values, checked once
            if (!reset_checked) begin
                reset_checked = 1'b1;
                if (read_done !== 1'b1 || write_done !== 1'b1 || rdata !== '0 ||
                    meip !== 1'b0 || seip !== 1'b0) begin
                    $display("ERR %0t: outputs not at reset values", $time);
                    error_count++;
                end
            end
        end else begin
            if (!read_done || !write_done) begin
                busy       = 1'b1;
                saw_read   = saw_read || !read_done;
                saw_write  = saw_write || !write_done;
                low_cycles = low_cycles + 1;
            end else if (busy) begin
                // done just came back
                done_count++;
                // only the flag of the request direction drops
                if (saw_write != exp_write || saw_read == exp_write) begin
                    $display("ERR %0t: done flags read %b write %b, expected %s", $time,
                             saw_read, saw_write, exp_write ? "write" : "read");
                    error_count++;
                end
                if (low_cycles != exp_cycles) begin
                    $display("ERR %0t: %s done after %0d cycles, expected %0d", $time,
                             exp_write ? "write" : "read", low_cycles, exp_cycles);
                    error_count++;
                end
                if (!exp_write && rdata !== exp_rdata) begin
                    $display("ERR %0t: rdata %h, expected %h", $time, rdata, exp_rdata);
                    error_count++;
                end
                busy       = 1'b0;
                saw_read   = 1'b0;
                saw_write  = 1'b0;
                low_cycles = 0;
            end
            // interrupt lines once per vector
            if (irq_chk) begin
                if (meip !== exp_meip) begin
                    $display("ERR %0t: meip %b, expected %b", $time, meip, exp_meip);
                    error_count++;
                end
                if (seip !== exp_seip) begin
                    $display("ERR %0t: seip %b, expected %b", $time, seip, exp_seip);
                    error_count++;
                end
            end
        end
    end

endmodule

// ==== testbench/tb_soc_bus.sv ====
`timescale 1ns/100ps

module tb_soc_bus import soc_pkg::*; ();

    logic                 CLOCK_50 = 1'b0;
    logic                 KEY0;
    logic [ADDR_W-1:0]    addr;
    logic [LS_TYPE_W-1:0] ls_type;
    logic [DATA_W-1:0]    wdata;
    logic                 read_enable;
    logic                 write_enable;
    logic                 key_valid;
    logic [7:0]           key_ascii;
    logic [NUM_SRC:0]     irq_src;
    logic [DATA_W-1:0]    rdata;
    logic                 read_done;
    logic                 write_done;
    logic                 meip;
    logic                 seip;

    // expected values for the checker
    logic [DATA_W-1:0] exp_rdata;
    logic [1:0]        exp_cycles;
    logic              exp_write;
    logic              irq_chk;
    logic              exp_meip;
    logic              exp_seip;
    int                checker_errors;
    int                tb_errors;
    // requests issued and completions seen
    int                req_count;
    int                done_count;

    // seven words per vector: op ls addr wdata rdata meip seip
    logic [63:0] vec_mem [0:447];
    int num_vec;
    int cycle_count = 0;
    int cycle_limit = 50;

    soc_bus uut (
        .CLOCK_50     (CLOCK_50),
        .KEY0         (KEY0),
        .addr         (addr),
        .ls_type      (ls_type),
        .wdata        (wdata),
        .read_enable  (read_enable),
        .write_enable (write_enable),
        .key_valid    (key_valid),
        .key_ascii    (key_ascii),
        .irq_src      (irq_src),
        .rdata        (rdata),
        .read_done    (read_done),
        .write_done   (write_done),
        .meip         (meip),
        .seip         (seip)
    );

    bus_checker u_checker (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .read_done   (read_done),
        .write_done  (write_done),
        .rdata       (rdata),
        .meip        (meip),
        .seip        (seip),
        .exp_rdata   (exp_rdata),
        .exp_cycles  (exp_cycles),
        .exp_write   (exp_write),
        .irq_chk     (irq_chk),
        .exp_meip    (exp_meip),
        .exp_seip    (exp_seip),
        .error_count (checker_errors),
        .done_count  (done_count)
    );

    // 8 ns period
    always #4 CLOCK_50 = ~CLOCK_50;

    always @(posedge CLOCK_50) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run still going after %0d cycles", cycle_limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // ram doubles take one extra beat, everything else two
    function automatic logic [1:0] access_cycles(input logic [ADDR_W-1:0] a,
                                                 input logic [LS_TYPE_W-1:0] ls);
        logic [ADDR_W-1:0] rel;
        rel = a - RAM_BASE;
        if ((rel < RAM_WORDS * 4) && (ls == LS_D)) begin
            return 2'd3;
        end
        return 2'd2;
    endfunction

    task automatic wait_done();
        while (!(read_done && write_done)) begin
            @(posedge CLOCK_50);
            #1;
        end
    endtask

    task automatic run_vector(input int idx);
        logic [63:0] op;
        logic [DATA_W-1:0] v_wdata;
        int gap;
        op      = vec_mem[idx*7];
        v_wdata = vec_mem[idx*7+3];
        gap     = $urandom_range(3, 0);
        repeat (gap) @(posedge CLOCK_50);
        @(posedge CLOCK_50);
        #1;
        case (op)
            // idle for wdata cycles
            64'd0: repeat (v_wdata[3:0]) @(posedge CLOCK_50);
            // write or read
            64'd1, 64'd2: begin
                addr         = vec_mem[idx*7+2];
                ls_type      = vec_mem[idx*7+1][LS_TYPE_W-1:0];
                wdata        = v_wdata;
                exp_rdata    = vec_mem[idx*7+4];
                exp_cycles   = access_cycles(addr, ls_type);
                exp_write    = (op == 64'd1);
                req_count++;
                write_enable = (op == 64'd1);
                read_enable  = (op == 64'd2);
                @(posedge CLOCK_50);
                #1;
                read_enable  = 1'b0;
                write_enable = 1'b0;
                wait_done();
            end
            // one-cycle pulse on the source lines
            64'd3: begin
                irq_src = v_wdata[NUM_SRC:0];
                @(posedge CLOCK_50);
                #1;
                irq_src = '0;
            end
            // keystroke
            64'd4: begin
                key_ascii = v_wdata[7:0];
                key_valid = 1'b1;
                @(posedge CLOCK_50);
                #1;
                key_valid = 1'b0;
            end
            default: begin
                $display("vector %0d has an unknown op %0h", idx, op);
                tb_errors++;
            end
        endcase
        // interrupt lines checked one cycle later
        exp_meip = vec_mem[idx*7+5][0];
        exp_seip = vec_mem[idx*7+6][0];
        @(posedge CLOCK_50);
        #1;
        irq_chk = 1'b1;
        @(posedge CLOCK_50);
        #1;
        irq_chk = 1'b0;
    endtask

    initial begin
        int seed_ret;
        KEY0         = 1'b0;
        addr         = '0;
        ls_type      = '0;
        wdata        = '0;
        read_enable  = 1'b0;
        write_enable = 1'b0;
        key_valid    = 1'b0;
        key_ascii    = '0;
        irq_src      = '0;
        exp_rdata    = '0;
        exp_cycles   = 2'd2;
        exp_write    = 1'b0;
        irq_chk      = 1'b0;
        exp_meip     = 1'b0;
        exp_seip     = 1'b0;
        tb_errors    = 0;
        req_count    = 0;
        seed_ret     = $urandom(32'h94cf1d44);

        // unused slots keep an address-dependent marker
        for (int i = 0; i < 448; i++) begin
            vec_mem[i] = ~64'(i);
        end
        $readmemh("testbench/bus_vectors.txt", vec_mem);
        num_vec = 0;
        while (num_vec < 64 && vec_mem[num_vec*7] != ~64'(num_vec*7)) begin
            num_vec++;
        end
        if (num_vec == 0) begin
            $display("no vectors found in testbench/bus_vectors.txt");
            tb_errors++;
        end
        cycle_limit = 12 * num_vec + 50;

        repeat (5) @(posedge CLOCK_50);
        #1;
        KEY0 = 1'b1;

        for (int v = 0; v < num_vec; v++) begin
            run_vector(v);
        end
        repeat (2) @(posedge CLOCK_50);

        // every request must have finished exactly once
        if (done_count != req_count) begin
            $display("only %0d completions seen for %0d bus requests", done_count, req_count);
            tb_errors++;
        end

        $display("run complete: %0d vectors, %0d checker errors, %0d testbench errors",
                 num_vec, checker_errors, tb_errors);
        if (checker_errors == 0 && tb_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== testbench/bus_vectors.txt ====
// op ls_type addr wdata exp_rdata exp_meip exp_seip, all hex
// op: 0 idle (wdata cycles), 1 write, 2 read, 3 irq pulse (wdata bits), 4 key (wdata char)
2 2 40000000 0 0 0 0
1 2 80000000 11223344 0 0 0
1 0 80000001 AA 0 0 0
1 1 80000002 BEEF 0 0 0
2 2 80000000 0 BEEFAA44 0 0
2 4 80000002 0 BEEF 0 0
2 0 80000001 0 BEEFAA 0 0
1 3 80000010 0123456789ABCDEF 0 0 0
2 3 80000010 0 0123456789ABCDEF 0 0
2 2 80000014 0 01234567 0 0
4 0 0 41 0 0 0
2 4 10000000 0 41 0 0
1 2 0C000004 2 0 0 0
1 2 0C002000 2 0 1 0
2 2 0C001000 0 2 1 0
2 2 0C200004 0 1 0 0
1 2 0C000008 3 0 0 0
1 2 0C000010 5 0 0 0
1 2 0C002000 16 0 0 0
3 0 0 14 0 1 0
2 2 0C001000 0 14 1 0
2 2 0C200004 0 4 1 0
2 2 0C200004 0 2 0 0
3 0 0 14 0 1 0
1 2 0C200000 5 0 0 0
2 2 0C200004 0 0 0 0
2 2 0C001000 0 14 0 0
1 3 02004000 CAFEF00D12345678 0 0 0
2 3 02004000 0 CAFEF00D12345678 0 0
1 2 0C002080 4 0 0 1
2 2 0C201004 0 2 0 0
2 2 50000000 0 0 0 0
1 2 0C200000 0 0 1 0
2 2 0C201004 0 0 1 0
0 0 0 2 0 1 0

// ==== files.f ====
rtl/soc_pkg.sv
rtl/addr_decoder.sv
rtl/bus_ctrl.sv
rtl/ram_port.sv
rtl/key_timer_regs.sv
rtl/plic.sv
rtl/soc_bus.sv
testbench/bus_checker.sv
testbench/tb_soc_bus.sv
